// File: hw/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width.
`define XLEN 32

// architectural registers, x0 included.
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000

`endif

// File: hw/rv_pkg.sv
package rv_pkg;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_EXT_IMM,
        ALU_SRC_PC,
        ALU_SRC_PC_OLD,
        ALU_SRC_4
    } alu_src_e;

    typedef enum logic {
        RES_SRC_ALU_OUT,
        RES_SRC_MEM
    } res_src_e;

    typedef enum logic [1:0] {
        RF_WD_SRC_RES,
        RF_WD_SRC_PC,
        RF_WD_SRC_IMM,
        RF_WD_SRC_NONE
    } rf_wd_src_e;

    // opcodes carry a prefix since BRANCH, JAL and LUI are also state names.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEM_ADDR,
        MEM_READ,
        MEM_WB,
        MEM_WRITE,
        EXEC_R,
        EXEC_I,
        ALU_WB,
        BRANCH,
        JAL,
        LUI
    } fsm_state_e;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  rv_pkg::alu_op_e  alu_ctrl,
    output logic [`XLEN-1:0] y,
    output logic [3:0]       flags
);
    logic             do_sub;
    logic [`XLEN-1:0] b_eff;
    logic [`XLEN:0]   sum_ext;
    logic [`XLEN-1:0] sum;
    logic             zero;
    logic             negative;
    logic             carry;
    logic             overflow;

    assign do_sub  = (alu_ctrl == rv_pkg::ALU_SUB) || (alu_ctrl == rv_pkg::ALU_SLT);
    assign b_eff   = do_sub ? ~b : b;
    assign sum_ext = {1'b0, a} + {1'b0, b_eff} + {{`XLEN{1'b0}}, do_sub};
    assign sum     = sum_ext[`XLEN-1:0];

    assign zero     = (sum == '0);
    assign negative = sum[`XLEN-1];
    assign carry    = sum_ext[`XLEN];
    assign overflow = (a[`XLEN-1] == b_eff[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);

    assign flags = {overflow, carry, negative, zero}; // zero sits in bit 0.

    always_comb begin
        case (alu_ctrl)
            rv_pkg::ALU_ADD:    y = sum;
            rv_pkg::ALU_SUB:    y = sum;
            rv_pkg::ALU_AND:    y = a & b;
            rv_pkg::ALU_OR:     y = a | b;
            rv_pkg::ALU_XOR:    y = a ^ b;
            rv_pkg::ALU_SLT:    y = {{(`XLEN-1){1'b0}}, negative ^ overflow}; // signed less-than.
            rv_pkg::ALU_SLL:    y = a << b[4:0];
            rv_pkg::ALU_SRL:    y = a >> b[4:0];
            rv_pkg::ALU_PASS_B: y = b;
            default:            y = '0;
        endcase
    end

endmodule

// File: hw/extend.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module extend (
    input  logic [`XLEN-1:0] instr,
    input  rv_pkg::imm_src_e imm_src,
    output logic [`XLEN-1:0] imm
);
    always_comb begin
        case (imm_src)
            rv_pkg::IMM_I:
                imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::IMM_S:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::IMM_B:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::IMM_J:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            rv_pkg::IMM_U:
                imm = {instr[31:12], 12'b0}; // upper immediate, low bits zero.
            default:
                imm = '0;
        endcase
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module regfile (
    input  logic             clk,
    input  logic [4:0]       a1,
    input  logic [4:0]       a2,
    input  logic [4:0]       a3,
    input  logic [`XLEN-1:0] wd3,
    input  logic             we3,
    output logic [`XLEN-1:0] rd1,
    output logic [`XLEN-1:0] rd2
);
    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we3 && (a3 != 5'd0)) begin // x0 is never written.
            regs[a3] <= wd3;
        end
    end

    assign rd1 = (a1 == 5'd0) ? '0 : regs[a1];
    assign rd2 = (a2 == 5'd0) ? '0 : regs[a2];

endmodule

// File: hw/datapath_multicycle.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module datapath_multicycle (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`XLEN-1:0]     m_rd,
    input  logic                 rf_we,
    input  rv_pkg::imm_src_e     imm_src,
    input  rv_pkg::alu_op_e      alu_ctrl,
    input  rv_pkg::alu_src_e     alu_src_a,
    input  rv_pkg::alu_src_e     alu_src_b,
    input  rv_pkg::res_src_e     res_src,
    input  logic                 addr_src,
    input  logic                 en_ir,
    input  logic                 en_npc_r,
    input  logic                 en_oldpc_r,
    input  rv_pkg::rf_wd_src_e   rf_wd_src,
    output logic [`XLEN-1:0]     m_addr,
    output logic [3:0]           alu_flags,
    output logic [`XLEN-1:0]     m_wd,
    output logic [`XLEN-1:0]     instr,
    output logic [`XLEN-1:0]     pc
);
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] pc_old;
    logic [`XLEN-1:0] m_rd_r;
    logic [`XLEN-1:0] reg_rd1;
    logic [`XLEN-1:0] reg_rd2;
    logic [`XLEN-1:0] reg_wd3;
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;
    logic [`XLEN-1:0] ext_imm;
    logic [`XLEN-1:0] alu_op_a;
    logic [`XLEN-1:0] alu_op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] alu_out_r;

    always_comb begin
        case (res_src)
            rv_pkg::RES_SRC_ALU_OUT: result = alu_out_r;
            rv_pkg::RES_SRC_MEM:     result = m_rd_r;
            default:                 result = '1;
        endcase
    end

    // fetch takes pc + 4 straight from the alu, later loads come through result.
    assign pc_next = en_ir ? alu_out : result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (en_npc_r) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (en_oldpc_r) begin
            pc_old <= pc; // address of the instruction being executed.
        end
        if (en_ir) begin
            instr <= m_rd;
        end
    end

    assign m_addr = addr_src ? result : pc;

    always_comb begin
        case (rf_wd_src)
            rv_pkg::RF_WD_SRC_RES:  reg_wd3 = result;
            rv_pkg::RF_WD_SRC_PC:   reg_wd3 = pc;
            rv_pkg::RF_WD_SRC_IMM:  reg_wd3 = ext_imm;
            rv_pkg::RF_WD_SRC_NONE: reg_wd3 = '1;
            default:                reg_wd3 = '1;
        endcase
    end

    regfile u_regfile (
        .clk (clk),
        .a1  (instr[19:15]),
        .a2  (instr[24:20]),
        .a3  (instr[11:7]),
        .wd3 (reg_wd3),
        .we3 (rf_we),
        .rd1 (reg_rd1),
        .rd2 (reg_rd2)
    );

    always_ff @(posedge clk) begin
        m_rd_r    <= m_rd;
        rd1       <= reg_rd1;
        rd2       <= reg_rd2;
        alu_out_r <= alu_out;
    end

    assign m_wd = rd2;

    extend u_extend (
        .instr   (instr),
        .imm_src (imm_src),
        .imm     (ext_imm)
    );

    always_comb begin
        case (alu_src_a)
            rv_pkg::ALU_SRC_REG_1:   alu_op_a = rd1;
            rv_pkg::ALU_SRC_REG_2:   alu_op_a = rd2;
            rv_pkg::ALU_SRC_EXT_IMM: alu_op_a = ext_imm;
            rv_pkg::ALU_SRC_PC:      alu_op_a = pc;
            rv_pkg::ALU_SRC_PC_OLD:  alu_op_a = pc_old;
            rv_pkg::ALU_SRC_4:       alu_op_a = `XLEN'd4;
            default:                 alu_op_a = '0;
        endcase
    end

    always_comb begin
        case (alu_src_b)
            rv_pkg::ALU_SRC_REG_1:   alu_op_b = rd1;
            rv_pkg::ALU_SRC_REG_2:   alu_op_b = rd2;
            rv_pkg::ALU_SRC_EXT_IMM: alu_op_b = ext_imm;
            rv_pkg::ALU_SRC_PC:      alu_op_b = pc;
            rv_pkg::ALU_SRC_PC_OLD:  alu_op_b = pc_old;
            rv_pkg::ALU_SRC_4:       alu_op_b = `XLEN'd4;
            default:                 alu_op_b = '1;
        endcase
    end

    alu u_alu (
        .a        (alu_op_a),
        .b        (alu_op_b),
        .alu_ctrl (alu_ctrl),
        .y        (alu_out),
        .flags    (alu_flags)
    );

endmodule

// File: hw/control_fsm.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module control_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`XLEN-1:0]     instr,
    input  logic [3:0]           alu_flags,
    output logic                 rf_we,
    output rv_pkg::imm_src_e     imm_src,
    output rv_pkg::alu_op_e      alu_ctrl,
    output rv_pkg::alu_src_e     alu_src_a,
    output rv_pkg::alu_src_e     alu_src_b,
    output rv_pkg::res_src_e     res_src,
    output logic                 addr_src,
    output logic                 en_ir,
    output logic                 en_npc_r,
    output logic                 en_oldpc_r,
    output rv_pkg::rf_wd_src_e   rf_wd_src,
    output logic                 mem_we
);
    rv_pkg::fsm_state_e state;
    rv_pkg::fsm_state_e state_next;
    rv_pkg::opcode_e    opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               started;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    function automatic rv_pkg::alu_op_e decode_alu(input logic [2:0] f3, input logic sub);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = sub ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            3'b111:  op = rv_pkg::ALU_AND;
            default: op = rv_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    // holds the first fetch back by one cycle after reset is released.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= rv_pkg::FETCH;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started) begin
                state <= state_next;
            end
        end
    end

    always_comb begin
        case (state)
            rv_pkg::FETCH:  state_next = rv_pkg::DECODE;
            rv_pkg::DECODE: begin
                case (opcode)
                    rv_pkg::OPC_OP:     state_next = rv_pkg::EXEC_R;
                    rv_pkg::OPC_OP_IMM: state_next = rv_pkg::EXEC_I;
                    rv_pkg::OPC_LUI:    state_next = rv_pkg::LUI;
                    rv_pkg::OPC_LOAD:   state_next = rv_pkg::MEM_ADDR;
                    rv_pkg::OPC_STORE:  state_next = rv_pkg::MEM_ADDR;
                    rv_pkg::OPC_BRANCH: state_next = rv_pkg::BRANCH;
                    rv_pkg::OPC_JAL:    state_next = rv_pkg::JAL;
                    default:            state_next = rv_pkg::FETCH; // unknown opcode is a no-op.
                endcase
            end
            rv_pkg::MEM_ADDR: begin
                state_next = (opcode == rv_pkg::OPC_LOAD) ? rv_pkg::MEM_READ : rv_pkg::MEM_WRITE;
            end
            rv_pkg::MEM_READ: state_next = rv_pkg::MEM_WB;
            rv_pkg::EXEC_R:   state_next = rv_pkg::ALU_WB;
            rv_pkg::EXEC_I:   state_next = rv_pkg::ALU_WB;
            rv_pkg::JAL:      state_next = rv_pkg::ALU_WB; // link value is written back next.
            default:          state_next = rv_pkg::FETCH;
        endcase
    end

    always_comb begin
        rf_we      = 1'b0;
        imm_src    = rv_pkg::IMM_I;
        alu_ctrl   = rv_pkg::ALU_ADD;
        alu_src_a  = rv_pkg::ALU_SRC_REG_1;
        alu_src_b  = rv_pkg::ALU_SRC_REG_2;
        res_src    = rv_pkg::RES_SRC_ALU_OUT;
        addr_src   = 1'b0;
        en_ir      = 1'b0;
        en_npc_r   = 1'b0;
        en_oldpc_r = 1'b0;
        rf_wd_src  = rv_pkg::RF_WD_SRC_RES;
        mem_we     = 1'b0;

        case (state)
            rv_pkg::FETCH: begin
                en_ir      = 1'b1;
                en_npc_r   = 1'b1;
                en_oldpc_r = 1'b1;
                alu_src_a  = rv_pkg::ALU_SRC_PC;
                alu_src_b  = rv_pkg::ALU_SRC_4;
            end
            rv_pkg::DECODE: begin
                // branch or jump target, computed ahead of time.
                imm_src   = (opcode == rv_pkg::OPC_JAL) ? rv_pkg::IMM_J : rv_pkg::IMM_B;
                alu_src_a = rv_pkg::ALU_SRC_PC_OLD;
                alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::MEM_ADDR: begin
                imm_src   = (opcode == rv_pkg::OPC_STORE) ? rv_pkg::IMM_S : rv_pkg::IMM_I;
                alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::MEM_READ: begin
                addr_src = 1'b1;
            end
            rv_pkg::MEM_WB: begin
                rf_we   = 1'b1;
                res_src = rv_pkg::RES_SRC_MEM;
            end
            rv_pkg::MEM_WRITE: begin
                addr_src = 1'b1;
                mem_we   = 1'b1;
            end
            rv_pkg::EXEC_R: begin
                alu_ctrl = decode_alu(funct3, funct7[5]);
            end
            rv_pkg::EXEC_I: begin
                alu_ctrl  = decode_alu(funct3, 1'b0);
                alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::ALU_WB: begin
                rf_we = 1'b1;
            end
            rv_pkg::BRANCH: begin
                alu_ctrl = rv_pkg::ALU_SUB;
                en_npc_r = alu_flags[0] ^ funct3[0]; // beq on zero, bne on not zero.
            end
            rv_pkg::JAL: begin
                en_npc_r  = 1'b1;
                alu_ctrl  = rv_pkg::ALU_PASS_B;
                alu_src_b = rv_pkg::ALU_SRC_PC;
            end
            rv_pkg::LUI: begin
                rf_we     = 1'b1;
                imm_src   = rv_pkg::IMM_U;
                rf_wd_src = rv_pkg::RF_WD_SRC_IMM;
            end
            default: begin
                rf_we = 1'b0;
            end
        endcase

        if (!started) begin
            en_ir      = 1'b0;
            en_npc_r   = 1'b0;
            en_oldpc_r = 1'b0;
        end
    end

endmodule

// File: hw/multicycle_cpu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module multicycle_cpu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] m_rd,
    output logic [`XLEN-1:0] m_addr,
    output logic [`XLEN-1:0] m_wd,
    output logic             mem_we,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] instr
);
    logic               rf_we;
    rv_pkg::imm_src_e   imm_src;
    rv_pkg::alu_op_e    alu_ctrl;
    rv_pkg::alu_src_e   alu_src_a;
    rv_pkg::alu_src_e   alu_src_b;
    rv_pkg::res_src_e   res_src;
    logic               addr_src;
    logic               en_ir;
    logic               en_npc_r;
    logic               en_oldpc_r;
    rv_pkg::rf_wd_src_e rf_wd_src;
    logic [3:0]         alu_flags;

    control_fsm u_control_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .rf_we      (rf_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .addr_src   (addr_src),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .en_oldpc_r (en_oldpc_r),
        .rf_wd_src  (rf_wd_src),
        .mem_we     (mem_we)
    );

    datapath_multicycle u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .m_rd       (m_rd),
        .rf_we      (rf_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .addr_src   (addr_src),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .en_oldpc_r (en_oldpc_r),
        .rf_wd_src  (rf_wd_src),
        .m_addr     (m_addr),
        .alu_flags  (alu_flags),
        .m_wd       (m_wd),
        .instr      (instr),
        .pc         (pc)
    );

endmodule

// File: tests/tb_multicycle_cpu.sv
`timescale 1ns/1ps

module tb_multicycle_cpu;

    localparam logic [31:0] HALT = 32'h0000_006f; // jal x0, 0.

    logic        clk;
    logic        rst_n;
    logic [31:0] m_rd;
    logic [31:0] m_addr;
    logic [31:0] m_wd;
    logic        mem_we;
    logic [31:0] pc;
    logic [31:0] instr;

    logic [31:0] mem [1024];
    logic [31:0] prog [256];
    int          prog_len;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] halt_addr;
    logic [15:0] lfsr = 16'd19;
    string       cur_name;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    bit          running;
    int          cycle_cnt;
    int          cycle_limit;

    multicycle_cpu u_multicycle_cpu (
        .clk    (clk),
        .rst_n  (rst_n),
        .m_rd   (m_rd),
        .m_addr (m_addr),
        .m_wd   (m_wd),
        .mem_we (mem_we),
        .pc     (pc),
        .instr  (instr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign m_rd = mem[m_addr[11:2]]; // word addressed, combinational read.

    always @(posedge clk) begin
        if (mem_we) begin
            mem[m_addr[11:2]] <= m_wd;
        end
    end

    function automatic logic [31:0] fill_word(input int k);
        return 32'hf00d_0000 | k; // unused words carry their own index.
    endfunction

    function automatic logic [31:0] image_word(input int k);
        return (k < prog_len) ? prog[k] : fill_word(k);
    endfunction

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ISA level model; fills the expected store queues and returns the instruction count.
    function automatic int run_reference();
        logic [31:0] x [32];
        logic [31:0] rm [1024];
        logic [31:0] p;
        logic [31:0] np;
        logic [31:0] i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        int          steps;
        exp_addr.delete();
        exp_data.delete();
        for (int k = 0; k < 1024; k++) begin
            rm[k] = image_word(k);
        end
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        p     = '0;
        steps = 0;
        while (steps < 2000) begin
            i = rm[p[11:2]];
            steps++;
            if (i == HALT) begin
                halt_addr = p;
                return steps;
            end
            a     = x[i[19:15]];
            b     = x[i[24:20]];
            imm_i = {{20{i[31]}}, i[31:20]};
            imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
            np    = p + 4;
            case (i[6:0])
                7'h33: begin
                    case (i[14:12])
                        3'd0:    x[i[11:7]] = i[30] ? a - b : a + b;
                        3'd1:    x[i[11:7]] = a << b[4:0];
                        3'd2:    x[i[11:7]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4:    x[i[11:7]] = a ^ b;
                        3'd5:    x[i[11:7]] = a >> b[4:0];
                        3'd6:    x[i[11:7]] = a | b;
                        default: x[i[11:7]] = a & b;
                    endcase
                end
                7'h13: begin
                    case (i[14:12])
                        3'd0:    x[i[11:7]] = a + imm_i;
                        3'd2:    x[i[11:7]] = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                        3'd4:    x[i[11:7]] = a ^ imm_i;
                        3'd6:    x[i[11:7]] = a | imm_i;
                        default: x[i[11:7]] = a & imm_i;
                    endcase
                end
                7'h37: x[i[11:7]] = {i[31:12], 12'b0};
                7'h03: begin
                    ea         = a + imm_i;
                    x[i[11:7]] = rm[ea[11:2]];
                end
                7'h23: begin
                    ea           = a + imm_s;
                    rm[ea[11:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                7'h63: begin
                    if ((i[12] == 1'b0 && a == b) || (i[12] == 1'b1 && a != b)) begin
                        np = p + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    x[i[11:7]] = p + 4;
                    np = p + {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
                end
                default: ;
            endcase
            x[0] = '0;
            p    = np;
        end
        halt_addr = p;
        return steps;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // every store the core makes is matched in order against the model.
    always @(posedge clk) begin
        if (rst_n && mem_we) begin
            if (exp_addr.size() == 0) begin
                $display("%s: the core stored to %h where no store was expected", cur_name,
                         m_addr);
                error_count++;
            end else begin
                check({cur_name, " store address"}, exp_addr.pop_front(), m_addr);
                check({cur_name, " store data"}, exp_data.pop_front(), m_wd);
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("%s: timed out before the program reached its halt loop", cur_name);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800; // addi sign-extends, so round the upper part.
        emit({upper[31:12], rd, 7'b0110111});
        emit(encode_i(v[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [11:0] addr);
        emit(encode_s(addr, rs2, 5'd0));
    endtask

    task automatic run_test(input string name);
        int steps;
        int errs_before;
        errs_before = error_count;
        cur_name    = name;
        steps       = run_reference();
        @(negedge clk);
        rst_n = 1'b0;
        for (int k = 0; k < 1024; k++) begin
            mem[k] <= image_word(k);
        end
        repeat (2) begin
            @(negedge clk);
            check({name, " pc in reset"}, 32'd0, pc);
            check({name, " mem_we in reset"}, 32'd0, {31'd0, mem_we});
        end
        rst_n       = 1'b1;
        cycle_cnt   = 0;
        cycle_limit = steps * 6 + 50;
        running     = 1'b1;
        @(negedge clk);
        check({name, " first fetch address"}, 32'd0, m_addr);
        while (!(pc === halt_addr && instr === HALT)) begin // halt loop jumped onto itself.
            @(negedge clk);
        end
        running = 1'b0;
        if (exp_addr.size() != 0) begin
            $display("%s: %0d expected stores never happened", name, exp_addr.size());
            error_count++;
        end
        tests_run++;
        if (error_count == errs_before) begin
            $display("%s: done, no errors", name);
        end else begin
            $display("%s: done, %0d errors", name, error_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic test_rtype();
        logic [6:0] f7s [8] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
        logic [2:0] f3s [8] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};
        prog_len = 0;
        load_imm(5'd1, rand_bits(32));
        load_imm(5'd2, rand_bits(32));
        for (int k = 0; k < 8; k++) begin
            emit(encode_r(f7s[k], 5'd2, 5'd1, f3s[k], 5'd3));
            store_word(5'd3, 12'h400 + 12'(k * 4));
        end
        emit(HALT);
        run_test("rtype");
    endtask

    task automatic test_immediates();
        logic [2:0] f3s [6] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd0};
        logic [11:0] imm;
        prog_len = 0;
        load_imm(5'd1, rand_bits(32));
        for (int k = 0; k < 6; k++) begin
            imm = 12'(rand_bits(12));
            if (k == 5) begin
                imm[11] = 1'b1; // at least one negative immediate.
            end
            emit(encode_i(imm, 5'd1, f3s[k], 5'd4, 7'h13));
            store_word(5'd4, 12'h440 + 12'(k * 4));
        end
        emit({20'(rand_bits(20)), 5'd5, 7'b0110111});
        store_word(5'd5, 12'h460);
        emit(HALT);
        run_test("immediates");
    endtask

    task automatic test_load_store();
        prog_len = 0;
        load_imm(5'd1, rand_bits(32));
        load_imm(5'd2, rand_bits(32));
        store_word(5'd1, 12'h500);
        store_word(5'd2, 12'h504);
        emit(encode_i(12'h500, 5'd0, 3'd2, 5'd6, 7'h03));
        emit(encode_i(12'h504, 5'd0, 3'd2, 5'd7, 7'h03));
        emit(encode_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd8));
        store_word(5'd8, 12'h508);
        emit(encode_i(12'h500, 5'd0, 3'd2, 5'd0, 7'h03)); // load into x0 is dropped.
        store_word(5'd0, 12'h50c);
        emit(HALT);
        run_test("load_store");
    endtask

    task automatic test_branches();
        logic [31:0] a;
        a = rand_bits(32);
        prog_len = 0;
        load_imm(5'd1, a);
        load_imm(5'd2, a);
        load_imm(5'd3, a ^ (rand_bits(32) | 32'd1));
        emit(encode_b(13'd8, 5'd2, 5'd1, 3'd0));
        store_word(5'd1, 12'h600);
        emit(encode_b(13'd8, 5'd3, 5'd1, 3'd0));
        store_word(5'd1, 12'h604);
        emit(encode_b(13'd8, 5'd3, 5'd1, 3'd1));
        store_word(5'd3, 12'h608);
        emit(encode_b(13'd8, 5'd2, 5'd1, 3'd1));
        store_word(5'd3, 12'h60c);
        emit(HALT);
        run_test("branches");
    endtask

    task automatic test_jal();
        prog_len = 0;
        emit(encode_i(12'h0, 5'd0, 3'd0, 5'd0, 7'h13));
        emit(encode_j(21'd12, 5'd5));
        store_word(5'd0, 12'h700);
        store_word(5'd0, 12'h704);
        store_word(5'd5, 12'h708); // link is the jal address plus 4.
        emit(HALT);
        run_test("jal");
    endtask

    initial begin
        rst_n        = 1'b0;
        running      = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int k = 0; k < 1024; k++) begin
            mem[k] <= fill_word(k);
        end
        prog_len = 0;
        emit(HALT);
        run_test("reset");
        test_rtype();
        test_immediates();
        test_load_store();
        test_branches();
        test_jal();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/rv_pkg.sv
hw/alu.sv
hw/extend.sv
hw/regfile.sv
hw/datapath_multicycle.sv
hw/control_fsm.sv
hw/multicycle_cpu.sv
tests/tb_multicycle_cpu.sv

// File: Makefile
TOP       ?= tb_multicycle_cpu
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD     ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f tb.f --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
